/* bench/icache_mem_model.sv */
// serves one line request at a time, delays of 0 to 3 cycles are sampled as each phase starts
`timescale 1ns/10ps
`default_nettype none

module icache_mem_model (
    input  wire           clk,
    input  wire           arst_n,
    input  wire           mem_req,
    input  wire  [31:0]   mem_addr,
    input  wire  [1:0]    addr_delay,
    input  wire  [1:0]    data_delay,
    output logic          mem_addr_ok,
    output logic          mem_data_ok,
    output logic [127:0]  mem_rdata
);

    typedef enum logic [2:0] {
        ph_idle,
        ph_addr,
        ph_ack,
        ph_data,
        ph_done
    } phase_e;

    phase_e      phase_q;
    logic [1:0]  cnt_q;
    logic [31:0] line_q;

    // every word reads back as its own byte address with the top byte flipped
    function automatic logic [127:0] line_at(input logic [31:0] base);
        logic [127:0] l;
        logic [31:0]  a;
        a = base;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = {~a[31:24], a[23:0]};
            a = a + 32'd4;
        end
        return l;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q     <= ph_idle;
            cnt_q       <= 2'd0;
            line_q      <= 32'h0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
        end else begin
            case (phase_q)
                ph_idle: begin
                    if (mem_req) begin
                        cnt_q   <= addr_delay;
                        phase_q <= ph_addr;
                    end
                end
                ph_addr: begin
                    if (cnt_q == 2'd0) begin
                        mem_addr_ok <= 1'b1;
                        line_q      <= mem_addr;
                        phase_q     <= ph_ack;
                    end else begin
                        cnt_q <= cnt_q - 2'd1;
                    end
                end
                ph_ack: begin
                    mem_addr_ok <= 1'b0;
                    cnt_q       <= data_delay;
                    phase_q     <= ph_data;
                end
                ph_data: begin
                    if (cnt_q == 2'd0) begin
                        mem_data_ok <= 1'b1;
                        mem_rdata   <= line_at(line_q);
                        phase_q     <= ph_done;
                    end else begin
                        cnt_q <= cnt_q - 2'd1;
                    end
                end
                default: begin
                    // data pulse lasts one cycle
                    mem_data_ok <= 1'b0;
                    phase_q     <= ph_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
// fetch addresses are word aligned; resp_ready stalls and memory delays come from one LFSR
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

    localparam int num_tests   = 6;
    localparam int test_cycles = 200;
    localparam int clk_period  = 100;

    logic                   clk;
    logic                   arst_n       = 1'b0;
    logic                   req_valid    = 1'b0;
    logic [31:0]            req_addr     = 32'h0;
    icache_pkg::icache_op_e req_op       = icache_pkg::op_fetch;
    logic                   req_uncached = 1'b0;
    logic                   resp_ready   = 1'b1;
    logic [1:0]             addr_delay   = 2'd0;
    logic [1:0]             data_delay   = 2'd0;
    logic                   req_ready;
    logic                   resp_valid;
    logic [63:0]            resp_rdata;
    logic                   resp_pair;
    logic                   mem_req;
    logic [31:0]            mem_addr;
    logic                   mem_uncached;
    logic                   mem_addr_ok;
    logic                   mem_data_ok;
    logic [127:0]           mem_rdata;

    logic                   exp_hit  = 1'b0;
    logic [31:0]            cur_addr = 32'h0;
    logic [31:0]            lfsr_q   = 32'd99645;
    logic                   acc_fetch;
    logic                   acc_inv;
    int                     fail_count = 0;
    int                     mem_reads  = 0;
    int                     exp_reads  = 0;
    int                     tests_run  = 0;
    int                     fails_at_start = 0;
    int                     reads_at_start = 0;

    icache dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_op       (req_op),
        .req_uncached (req_uncached),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .resp_pair    (resp_pair),
        .resp_ready   (resp_ready),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_uncached (mem_uncached),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .mem_rdata    (mem_rdata)
    );

    icache_mem_model u_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .addr_delay  (addr_delay),
        .data_delay  (data_delay),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // random source and expected values
    //////////////////////////////////////////////////

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [3:0] take_bits(input int n);
        logic [3:0] r;
        r = 4'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = galois_step(lfsr_q);
            r = {r[2:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // instruction word as the memory returns it
    function automatic logic [31:0] instr_at(input logic [31:0] a);
        return {~a[31:24], a[23:0]};
    endfunction

    function automatic logic [63:0] exp_rdata(input logic [31:0] a);
        if (a[2]) begin
            return {32'h0, instr_at(a)};
        end
        return {instr_at(a + 32'd4), instr_at(a)};
    endfunction

    function automatic logic [31:0] addr_of(input logic [23:0] tag, input logic [3:0] idx,
                                            input logic [1:0] w);
        return {tag, idx, w, 2'b00};
    endfunction

    // one stall in four on resp_ready
    always @(posedge clk) begin : draw
        logic [3:0] bits;
        bits = take_bits(2);
        resp_ready <= (bits != 4'd0);
        bits = take_bits(2);
        addr_delay <= bits[1:0];
        bits = take_bits(2);
        data_delay <= bits[1:0];
    end

    assign acc_fetch = req_valid && req_ready && (req_op == icache_pkg::op_fetch);
    assign acc_inv   = req_valid && req_ready && (req_op == icache_pkg::op_index_inv);

    always @(posedge clk) begin
        if (acc_fetch) begin
            cur_addr <= req_addr;
        end
        if (arst_n && mem_req && mem_addr_ok) begin
            mem_reads <= mem_reads + 1;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && resp_ready |-> resp_rdata == exp_rdata(cur_addr))
        else begin
            fail_count++;
            $display("error resp_rdata: got %h expected %h", $sampled(resp_rdata),
                     exp_rdata($sampled(cur_addr)));
        end

    a_pair: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && resp_ready |-> resp_pair == !cur_addr[2])
        else begin
            fail_count++;
            $display("error resp_pair: got %h expected %h", $sampled(resp_pair),
                     !$sampled(cur_addr[2]));
        end

    a_hit_timing: assert property (@(posedge clk) disable iff (!arst_n)
        acc_fetch && exp_hit |=> !resp_valid ##1 (resp_valid && !mem_req))
        else begin
            fail_count++;
            $display("expected hit did not respond one cycle after lookup without memory");
        end

    // mem_uncached must follow the request kind
    a_miss: assert property (@(posedge clk) disable iff (!arst_n)
        acc_fetch && !exp_hit |-> ##2 (mem_req && mem_uncached == $past(req_uncached, 2)))
        else begin
            fail_count++;
            $display("expected miss did not raise mem_req with the right uncached flag");
        end

    // line-aligned address of the fetch in flight
    a_mem_addr: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> mem_addr == (cur_addr & 32'hffff_fff0))
        else begin
            fail_count++;
            $display("error mem_addr: got %h expected %h", $sampled(mem_addr),
                     $sampled(cur_addr) & 32'hffff_fff0);
        end

    a_inv_silent: assert property (@(posedge clk) disable iff (!arst_n)
        acc_inv |=> !resp_valid [*2])
        else begin
            fail_count++;
            $display("index invalidate produced a response");
        end

    a_stall: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready |-> !req_ready ##1
            (resp_valid && $stable(resp_rdata) && $stable(resp_pair)))
        else begin
            fail_count++;
            $display("response changed or request taken while resp_ready was low");
        end

    a_reset_state: assert property (@(posedge clk)
        $rose(arst_n) |-> !resp_valid && !mem_req && req_ready)
        else begin
            fail_count++;
            $display("outputs not in idle state right after reset");
        end

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////

    // starts on a rising edge, returns on the accepting edge with req_valid still high
    task automatic issue(input logic [31:0] addr, input icache_pkg::icache_op_e op,
                         input logic unc, input logic hit_exp);
        req_valid    <= 1'b1;
        req_addr     <= addr;
        req_op       <= op;
        req_uncached <= unc;
        exp_hit      <= hit_exp;
        if (op == icache_pkg::op_fetch && !hit_exp) begin
            exp_reads++;
        end
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);
    endtask

    task automatic wait_resp();
        do begin
            @(negedge clk);
        end while (!(resp_valid && resp_ready));
        @(posedge clk);
    endtask

    task automatic fetch(input logic [31:0] addr, input logic unc, input logic hit_exp);
        issue(addr, icache_pkg::op_fetch, unc, hit_exp);
        req_valid <= 1'b0;
        wait_resp();
    endtask

    task automatic report_test(input string name);
        a_reads: assert (mem_reads - reads_at_start == exp_reads)
            else begin
                fail_count++;
                $display("error mem_reads: got %h expected %h", mem_reads - reads_at_start,
                         exp_reads);
            end
        tests_run++;
        $display("test %s checks failed %0d, memory reads %0d", name,
                 fail_count - fails_at_start, mem_reads - reads_at_start);
        fails_at_start = fail_count;
        reads_at_start = mem_reads;
        exp_reads      = 0;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // refill then hit every offset, plus an odd-offset refill
        fetch(addr_of(24'h00a001, 4'd1, 2'd0), 1'b0, 1'b0);
        for (int w = 1; w < 4; w++) begin
            fetch(addr_of(24'h00a001, 4'd1, w[1:0]), 1'b0, 1'b1);
        end
        fetch(addr_of(24'h00b002, 4'd2, 2'd3), 1'b0, 1'b0);
        fetch(addr_of(24'h00b002, 4'd2, 2'd2), 1'b0, 1'b1);
        report_test("data");

        fetch(addr_of(24'h00a001, 4'd1, 2'd2), 1'b0, 1'b1);
        fetch(addr_of(24'h00b002, 4'd2, 2'd1), 1'b0, 1'b1);
        report_test("hit");

        // A and B fill set 5, touching A makes B the victim of C
        fetch(addr_of(24'h0000a5, 4'd5, 2'd0), 1'b0, 1'b0);
        fetch(addr_of(24'h0000b5, 4'd5, 2'd1), 1'b0, 1'b0);
        fetch(addr_of(24'h0000a5, 4'd5, 2'd2), 1'b0, 1'b1);
        fetch(addr_of(24'h0000c5, 4'd5, 2'd3), 1'b0, 1'b0);
        fetch(addr_of(24'h0000a5, 4'd5, 2'd1), 1'b0, 1'b1);
        fetch(addr_of(24'h0000b5, 4'd5, 2'd0), 1'b0, 1'b0);
        report_test("lru");

        fetch(addr_of(24'h0000d7, 4'd7, 2'd0), 1'b1, 1'b0);
        fetch(addr_of(24'h0000d7, 4'd7, 2'd3), 1'b1, 1'b0);
        fetch(addr_of(24'h0000d7, 4'd7, 2'd2), 1'b0, 1'b0);
        fetch(addr_of(24'h0000d7, 4'd7, 2'd1), 1'b0, 1'b1);
        report_test("uncache");

        fetch(addr_of(24'h0000e9, 4'd9, 2'd0), 1'b0, 1'b0);
        fetch(addr_of(24'h0000f9, 4'd9, 2'd1), 1'b0, 1'b0);
        fetch(addr_of(24'h0000e9, 4'd9, 2'd2), 1'b0, 1'b1);
        fetch(addr_of(24'h0000f9, 4'd9, 2'd3), 1'b0, 1'b1);
        issue(addr_of(24'h000000, 4'd9, 2'd0), icache_pkg::op_index_inv, 1'b0, 1'b0);
        req_valid <= 1'b0;
        @(posedge clk);
        fetch(addr_of(24'h0000e9, 4'd9, 2'd0), 1'b0, 1'b0);
        fetch(addr_of(24'h0000f9, 4'd9, 2'd1), 1'b0, 1'b0);
        report_test("inval");

        // hits issued back to back so a request enters as a response leaves
        for (int i = 0; i < 8; i++) begin
            if (i[0]) begin
                issue(addr_of(24'h00b002, 4'd2, i[2:1]), icache_pkg::op_fetch, 1'b0, 1'b1);
            end else begin
                issue(addr_of(24'h00a001, 4'd1, i[2:1]), icache_pkg::op_fetch, 1'b0, 1'b1);
            end
        end
        req_valid <= 1'b0;
        wait_resp();
        report_test("stall");

        repeat (4) @(posedge clk);
        $display("tests run %0d, checks failed %0d, memory reads %0d",
                 tests_run, fail_count, mem_reads);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(num_tests * test_cycles * clk_period);
        $display("timeout: run did not finish within %0d cycles", num_tests * test_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/icache_pkg.sv
hw/icache_lru.sv
hw/icache_data.sv
hw/icache_tagv.sv
hw/icache_ctrl.sv
hw/icache.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

/* hw/icache.sv */
// 2-way 16-set cache, no translation, fetch returns two words only on even offsets
`timescale 1ns/10ps
`default_nettype none

module icache (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               req_valid,
    input  wire  [31:0]                       req_addr,
    input  wire  icache_pkg::icache_op_e      req_op,
    input  wire                               req_uncached,
    output logic                              req_ready,
    output logic                              resp_valid,
    output logic [63:0]                       resp_rdata,
    output logic                              resp_pair,
    input  wire                               resp_ready,
    output logic                              mem_req,
    output logic [31:0]                       mem_addr,
    output logic                              mem_uncached,
    input  wire                               mem_addr_ok,
    input  wire                               mem_data_ok,
    input  wire  [icache_pkg::line_w-1:0]     mem_rdata
);

    logic                            rd_en;
    logic [icache_pkg::index_w-1:0]  rd_index;
    logic [icache_pkg::tag_w-1:0]    cmp_tag;
    logic [icache_pkg::ways-1:0]     hit;
    logic [icache_pkg::line_w-1:0]   way_line0;
    logic [icache_pkg::line_w-1:0]   way_line1;
    logic [icache_pkg::ways-1:0]     fill_we;
    logic [icache_pkg::index_w-1:0]  fill_index;
    logic [icache_pkg::tag_w-1:0]    fill_tag;
    logic [icache_pkg::line_w-1:0]   fill_line;
    logic                            inv_valid;
    logic [icache_pkg::index_w-1:0]  inv_index;
    logic [icache_pkg::index_w-1:0]  lru_index;
    logic                            lru_touch_valid;
    logic                            lru_touch_way;
    logic                            victim_way;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .req_op          (req_op),
        .req_uncached    (req_uncached),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .resp_rdata      (resp_rdata),
        .resp_pair       (resp_pair),
        .resp_ready      (resp_ready),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr),
        .mem_uncached    (mem_uncached),
        .mem_addr_ok     (mem_addr_ok),
        .mem_data_ok     (mem_data_ok),
        .mem_rdata       (mem_rdata),
        .rd_en           (rd_en),
        .rd_index        (rd_index),
        .cmp_tag         (cmp_tag),
        .hit             (hit),
        .way_line0       (way_line0),
        .way_line1       (way_line1),
        .fill_we         (fill_we),
        .fill_index      (fill_index),
        .fill_tag        (fill_tag),
        .fill_line       (fill_line),
        .inv_valid       (inv_valid),
        .inv_index       (inv_index),
        .lru_index       (lru_index),
        .lru_touch_valid (lru_touch_valid),
        .lru_touch_way   (lru_touch_way),
        .victim_way      (victim_way)
    );

    icache_tagv u_tagv (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .cmp_tag   (cmp_tag),
        .wr_we     (fill_we),
        .wr_index  (fill_index),
        .wr_tag    (fill_tag),
        .inv_valid (inv_valid),
        .inv_index (inv_index),
        .hit       (hit)
    );

    icache_data u_data (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .wr_we    (fill_we),
        .wr_index (fill_index),
        .wr_line  (fill_line),
        .rd_line0 (way_line0),
        .rd_line1 (way_line1)
    );

    icache_lru u_lru (
        .clk         (clk),
        .arst_n      (arst_n),
        .lru_index   (lru_index),
        .touch_valid (lru_touch_valid),
        .touch_way   (lru_touch_way),
        .victim_way  (victim_way)
    );

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
// one request in flight, memory returns a whole line, uncached fetches never allocate
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
    input  wire                               clk,
    input  wire                               arst_n,
    // fetch side
    input  wire                               req_valid,
    input  wire  [31:0]                       req_addr,
    input  wire  icache_pkg::icache_op_e      req_op,
    input  wire                               req_uncached,
    output logic                              req_ready,
    output logic                              resp_valid,
    output logic [63:0]                       resp_rdata,
    output logic                              resp_pair,
    input  wire                               resp_ready,
    // memory side
    output logic                              mem_req,
    output logic [31:0]                       mem_addr,
    output logic                              mem_uncached,
    input  wire                               mem_addr_ok,
    input  wire                               mem_data_ok,
    input  wire  [icache_pkg::line_w-1:0]     mem_rdata,
    // tag and data arrays
    output logic                              rd_en,
    output logic [icache_pkg::index_w-1:0]    rd_index,
    output logic [icache_pkg::tag_w-1:0]      cmp_tag,
    input  wire  [icache_pkg::ways-1:0]       hit,
    input  wire  [icache_pkg::line_w-1:0]     way_line0,
    input  wire  [icache_pkg::line_w-1:0]     way_line1,
    output logic [icache_pkg::ways-1:0]       fill_we,
    output logic [icache_pkg::index_w-1:0]    fill_index,
    output logic [icache_pkg::tag_w-1:0]      fill_tag,
    output logic [icache_pkg::line_w-1:0]     fill_line,
    output logic                              inv_valid,
    output logic [icache_pkg::index_w-1:0]    inv_index,
    // lru
    output logic [icache_pkg::index_w-1:0]    lru_index,
    output logic                              lru_touch_valid,
    output logic                              lru_touch_way,
    input  wire                               victim_way
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_req,
        st_wait,
        st_resp
    } state_e;

    state_e                          state_q;
    state_e                          state_d;
    logic [31:0]                     addr_q;
    icache_pkg::icache_op_e          op_q;
    logic                            unc_q;
    logic                            hit_way_q;
    logic                            from_mem_q;
    logic [icache_pkg::line_w-1:0]   refill_q;
    logic                            accept;
    logic                            lookup_hit;
    logic                            fill;
    logic [icache_pkg::offset_w-1:0] word;
    logic [icache_pkg::line_w-1:0]   resp_line;

    //////////////////////////////////////////////////
    // request buffer and state machine
    //////////////////////////////////////////////////

    // a taken response frees the slot for a new request in the same cycle
    assign req_ready = (state_q == st_idle) || (state_q == st_resp && resp_ready);
    assign accept    = req_valid && req_ready;

    assign lookup_hit = (state_q == st_lookup) && (op_q == icache_pkg::op_fetch) &&
                        !unc_q && (|hit);
    assign fill       = (state_q == st_wait) && mem_data_ok && !unc_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (op_q == icache_pkg::op_index_inv) begin
                    state_d = st_idle;
                end else if (lookup_hit) begin
                    state_d = st_resp;
                end else begin
                    state_d = st_req;
                end
            end
            st_req: begin
                if (mem_addr_ok) begin
                    state_d = st_wait;
                end
            end
            st_wait: begin
                if (mem_data_ok) begin
                    state_d = st_resp;
                end
            end
            st_resp: begin
                if (resp_ready) begin
                    state_d = accept ? st_lookup : st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_addr;
            op_q   <= req_op;
            unc_q  <= req_uncached;
        end
        if (state_q == st_lookup) begin
            hit_way_q  <= hit[1];
            from_mem_q <= !lookup_hit;
        end
        if (state_q == st_wait && mem_data_ok) begin
            refill_q <= mem_rdata;
        end
    end

    //////////////////////////////////////////////////
    // array, lru and memory controls
    //////////////////////////////////////////////////

    assign rd_en    = accept;
    assign rd_index = icache_pkg::addr_index(req_addr);
    assign cmp_tag  = icache_pkg::addr_tag(addr_q);

    // refill lands in the lru victim
    assign fill_we    = fill ? (victim_way ? 2'b10 : 2'b01) : 2'b00;
    assign fill_index = icache_pkg::addr_index(addr_q);
    assign fill_tag   = icache_pkg::addr_tag(addr_q);
    assign fill_line  = mem_rdata;

    assign inv_valid = (state_q == st_lookup) && (op_q == icache_pkg::op_index_inv);
    assign inv_index = icache_pkg::addr_index(addr_q);

    assign lru_index       = icache_pkg::addr_index(addr_q);
    assign lru_touch_valid = lookup_hit || fill;
    assign lru_touch_way   = (state_q == st_lookup) ? hit[1] : victim_way;

    assign mem_req      = (state_q == st_req);
    assign mem_addr     = {addr_q[31:icache_pkg::offset_w+2], {(icache_pkg::offset_w+2){1'b0}}};
    assign mem_uncached = unc_q;

    //////////////////////////////////////////////////
    // fetch word selection
    //////////////////////////////////////////////////

    assign word      = icache_pkg::addr_word(addr_q);
    assign resp_line = from_mem_q ? refill_q : (hit_way_q ? way_line1 : way_line0);

    always_comb begin
        if (!word[0]) begin
            // even offset, second instruction sits in the same line
            resp_rdata = resp_line[word*32 +: 64];
            resp_pair  = 1'b1;
        end else begin
            resp_rdata = {32'h0, resp_line[word*32 +: 32]};
            resp_pair  = 1'b0;
        end
    end

    assign resp_valid = (state_q == st_resp);

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr))
        else $error("mem_req dropped or address moved before mem_addr_ok");

    a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_pair))
        else $error("response changed while stalled");

endmodule

`default_nettype wire

/* hw/icache_data.sv */
// no reset on the arrays, read outputs change only when rd_en is high
`timescale 1ns/10ps
`default_nettype none

module icache_data (
    input  wire                               clk,
    input  wire                               rd_en,
    input  wire  [icache_pkg::index_w-1:0]    rd_index,
    input  wire  [icache_pkg::ways-1:0]       wr_we,
    input  wire  [icache_pkg::index_w-1:0]    wr_index,
    input  wire  [icache_pkg::line_w-1:0]     wr_line,
    output logic [icache_pkg::line_w-1:0]     rd_line0,
    output logic [icache_pkg::line_w-1:0]     rd_line1
);

    //////////////////////////////////////////////////
    // one line array per way
    //////////////////////////////////////////////////

    for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
        logic [icache_pkg::line_w-1:0] mem [icache_pkg::sets];
        logic [icache_pkg::line_w-1:0] rd_q;

        always_ff @(posedge clk) begin
            // whole line replaced on refill
            if (wr_we[w]) begin
                mem[wr_index] <= wr_line;
            end
            if (rd_en) begin
                rd_q <= mem[rd_index];
            end
        end
    end

    assign rd_line0 = g_way[0].rd_q;
    assign rd_line1 = g_way[1].rd_q;

    // refill goes to a single victim way
    a_one_way_write: assert property (@(posedge clk) $onehot0(wr_we))
        else $error("line written to both ways");

endmodule

`default_nettype wire

/* hw/icache_lru.sv */
// two ways only, one bit per set, victim is valid in the same cycle as lru_index
`timescale 1ns/10ps
`default_nettype none

module icache_lru (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire  [icache_pkg::index_w-1:0]    lru_index,
    input  wire                               touch_valid,
    input  wire                               touch_way,
    output logic                              victim_way
);

    // bit set means way 1 is least recently used
    logic [icache_pkg::sets-1:0] lru_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;
        end else if (touch_valid) begin
            // the way not touched becomes the victim
            lru_q[lru_index] <= ~touch_way;
        end
    end

    assign victim_way = lru_q[lru_index];

endmodule

`default_nettype wire

/* hw/icache_pkg.sv */
// geometry is fixed at 32-bit byte addresses, word-aligned fetches and two ways only
`default_nettype none

package icache_pkg;

    //////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////

    localparam int index_w  = 4;
    localparam int offset_w = 2;
    localparam int ways     = 2;
    localparam int sets     = 1 << index_w;
    // two byte-offset bits below the word offset
    localparam int tag_w    = 32 - index_w - offset_w - 2;
    localparam int line_w   = 32 << offset_w;

    // request kind
    typedef enum logic {
        op_fetch     = 1'b0,
        op_index_inv = 1'b1
    } icache_op_e;

    //////////////////////////////////////////////////
    // address field helpers
    //////////////////////////////////////////////////

    function automatic logic [tag_w-1:0] addr_tag(input logic [31:0] addr);
        return addr[31 -: tag_w];
    endfunction

    function automatic logic [index_w-1:0] addr_index(input logic [31:0] addr);
        return addr[offset_w + 2 +: index_w];
    endfunction

    function automatic logic [offset_w-1:0] addr_word(input logic [31:0] addr);
        return addr[2 +: offset_w];
    endfunction

endpackage

`default_nettype wire

/* hw/icache_tagv.sv */
// tags have no reset, valid bits do; hit is only meaningful the cycle after a read
`timescale 1ns/10ps
`default_nettype none

module icache_tagv (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               rd_en,
    input  wire  [icache_pkg::index_w-1:0]    rd_index,
    input  wire  [icache_pkg::tag_w-1:0]      cmp_tag,
    input  wire  [icache_pkg::ways-1:0]       wr_we,
    input  wire  [icache_pkg::index_w-1:0]    wr_index,
    input  wire  [icache_pkg::tag_w-1:0]      wr_tag,
    input  wire                               inv_valid,
    input  wire  [icache_pkg::index_w-1:0]    inv_index,
    output logic [icache_pkg::ways-1:0]       hit
);

    logic [icache_pkg::index_w-1:0] rd_index_q;
    logic                           inv_rd;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_index_q <= rd_index;
        end
    end

    // an invalidate of the set just read kills the hit at once
    assign inv_rd = inv_valid && (inv_index == rd_index_q);

    //////////////////////////////////////////////////
    // per-way tag and valid store
    //////////////////////////////////////////////////

    for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
        logic [icache_pkg::tag_w-1:0] tag_mem [icache_pkg::sets];
        logic [icache_pkg::sets-1:0]  valid_q;
        logic [icache_pkg::tag_w-1:0] tag_rd_q;
        logic                         valid_rd_q;

        always_ff @(posedge clk) begin
            if (wr_we[w]) begin
                tag_mem[wr_index] <= wr_tag;
            end
            if (rd_en) begin
                tag_rd_q <= tag_mem[rd_index];
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q    <= '0;
                valid_rd_q <= 1'b0;
            end else begin
                if (wr_we[w]) begin
                    valid_q[wr_index] <= 1'b1;
                end
                // invalidate wins over a fill of the same set
                if (inv_valid) begin
                    valid_q[inv_index] <= 1'b0;
                end
                if (rd_en) begin
                    valid_rd_q <= valid_q[rd_index];
                end
            end
        end

        assign hit[w] = valid_rd_q && !inv_rd && (tag_rd_q == cmp_tag);
    end

    // a line lives in at most one way
    a_hit_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hit))
        else $error("tag hit in both ways");

endmodule

`default_nettype wire
